/* files.f */
video_mon_pkg.sv
pixel_rx.sv
frame_monitor.sv
report_tx.sv
video_mon_top.sv
video_mon_properties.sv
tb_video_mon.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_video_mon -f files.f

./obj_dir/Vtb_video_mon | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

/* tb_video_mon.sv */
// Directed testbench for video_mon_top, using a 4x3 frame geometry throughout.
// Expected reports come from a frame model fed with the same beats as the DUT.
// Every test starts from reset, so frame_id and frame_num restart at 0.
module tb_video_mon import video_mon_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 1000;  // Cycles allowed for any single wait
    localparam int FRAME_W = 4;
    localparam int FRAME_H = 3;

    logic              mon_axi4s;
    logic              rst;
    frame_size_t       frame_size;
    logic              pix_req;
    pixel_beat_t       pix_beat;
    logic              pix_ack;
    logic              rep_req;
    frame_report_t     rep;
    logic              rep_ack;
    logic [F_BITS-1:0] frame_num;

    logic [15:0]       lfsr;        // Pixel generator state
    pixel_beat_t       beat_q[$];   // Beats still to be sent
    frame_report_t     exp_q[$];    // Reports the model expects, in order
    int                acked;       // Reports acknowledged since reset
    logic              m_open;      // Model has a frame open
    logic [F_BITS-1:0] m_id;
    logic [X_BITS-1:0] m_cols;
    frame_report_t     m_rep;       // Report being built for the open frame

    video_mon_top dut (
        .mon_axi4s  (mon_axi4s),
        .rst        (rst),
        .frame_size (frame_size),
        .pix_req    (pix_req),
        .pix_beat   (pix_beat),
        .pix_ack    (pix_ack),
        .rep_req    (rep_req),
        .rep        (rep),
        .rep_ack    (rep_ack),
        .frame_num  (frame_num)
    );

    always #20 mon_axi4s = ~mon_axi4s;

    // Fibonacci LFSR with taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_pixel(output pixel_t p);
        logic [COMPONENTS*DATA_BITS-1:0] bits;
        for (int i = 0; i < COMPONENTS*DATA_BITS; i++) begin
            lfsr    = lfsr_next(lfsr);
            bits[i] = lfsr[0];                          // One step per bit taken
        end
        p = bits;
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_report(input string test, input frame_report_t exp,
                                  input frame_report_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s report: expected %h, actual %h",
                                test, exp, act));
        end
    endtask

    task automatic compare_count(input string test, input logic [F_BITS-1:0] exp,
                                 input logic [F_BITS-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s frame_num: expected %0d, actual %0d",
                                test, exp, act));
        end
    endtask

    task automatic model_close(input logic ok);
        m_rep.frame_id = m_id;
        m_rep.size_ok  = m_rep.size_ok && ok;
        exp_q.push_back(m_rep);
        m_id   = m_id + 1'b1;
        m_open = 1'b0;
    endtask

    // Queue one beat for the DUT and run it through the frame model
    task automatic add_beat(input pixel_t data, input logic sof, input logic eol);
        pixel_beat_t b;
        b.data = data;
        b.sof  = sof;
        b.eol  = eol;
        beat_q.push_back(b);
        if (sof && m_open) begin
            model_close(1'b0);                          // Cut short by a new frame
        end
        if (sof) begin
            m_open        = 1'b1;
            m_cols        = '0;
            m_rep         = '0;
            m_rep.size_ok = 1'b1;
        end
        if (m_open) begin
            for (int i = 0; i < COMPONENTS; i++) begin
                m_rep.sums[i] = m_rep.sums[i] + SUM_BITS'(data[i]);
            end
            m_rep.pixel_count = m_rep.pixel_count + 1'b1;
            m_cols            = m_cols + 1'b1;
            if (eol) begin
                m_rep.line_count = m_rep.line_count + 1'b1;
                if (m_cols != X_BITS'(FRAME_W)) begin
                    m_rep.size_ok = 1'b0;
                end
                m_cols = '0;
                if (m_rep.line_count == Y_BITS'(FRAME_H)) begin
                    model_close(1'b1);
                end
            end
        end
    endtask

    // Frame of random pixels starting with sof; short_line gets one pixel less
    task automatic add_frame(input int lines, input int short_line);
        pixel_t p;
        int     n;
        for (int l = 0; l < lines; l++) begin
            n = (l == short_line) ? FRAME_W - 1 : FRAME_W;
            for (int c = 0; c < n; c++) begin
                random_pixel(p);
                add_beat(p, l == 0 && c == 0, c == n - 1);
            end
        end
    endtask

    task automatic add_loose_beats(input int count);
        pixel_t p;
        for (int i = 0; i < count; i++) begin
            random_pixel(p);
            add_beat(p, 1'b0, 1'b0);
        end
    endtask

    task automatic send_beat(input pixel_beat_t b);
        int n;
        @(posedge mon_axi4s);
        pix_beat <= b;
        pix_req  <= 1'b1;
        n = 0;
        do begin
            @(negedge mon_axi4s);
            n++;
            if (n > TIMEOUT) begin
                abort_run("Timed out waiting for pix_ack to rise");
            end
        end while (!pix_ack);
        @(posedge mon_axi4s);
        pix_req <= 1'b0;
        n = 0;
        do begin
            @(negedge mon_axi4s);
            n++;
            if (n > TIMEOUT) begin
                abort_run("Timed out waiting for pix_ack to fall");
            end
        end while (pix_ack);
    endtask

    task automatic expect_report(input string test, input int ack_delay);
        frame_report_t exp;
        int            n;
        exp = exp_q.pop_front();
        n   = 0;
        do begin
            @(negedge mon_axi4s);
            n++;
            if (n > TIMEOUT) begin
                abort_run($sformatf("%s: no report arrived on rep_req", test));
            end
        end while (!rep_req);
        compare_report(test, exp, rep);
        repeat (ack_delay) @(posedge mon_axi4s);         // Slow receiver
        @(posedge mon_axi4s);
        rep_ack <= 1'b1;
        n = 0;
        do begin
            @(negedge mon_axi4s);
            n++;
            if (n > TIMEOUT) begin
                abort_run($sformatf("%s: rep_req stayed high after rep_ack", test));
            end
        end while (rep_req);
        acked++;
        compare_count(test, F_BITS'(acked), frame_num); // Counts up with the request drop
        @(posedge mon_axi4s);
        rep_ack <= 1'b0;
    endtask

    // Sender and receiver run side by side so back-pressure can build up
    task automatic run_frames(input string test, input int ack_delay);
        int reports;
        reports = exp_q.size();
        fork
            begin
                while (beat_q.size() > 0) begin
                    send_beat(beat_q.pop_front());
                end
            end
            begin
                for (int i = 0; i < reports; i++) begin
                    expect_report(test, ack_delay);
                end
            end
        join
    endtask

    task automatic apply_reset();
        @(posedge mon_axi4s);
        rst <= 1'b1;
        repeat (2) @(posedge mon_axi4s);
        rst <= 1'b0;
        beat_q.delete();
        exp_q.delete();
        acked  = 0;
        m_open = 1'b0;
        m_id   = '0;
    endtask

    task automatic test_clean_frame();
        apply_reset();
        add_frame(FRAME_H, -1);
        run_frames("clean_frame", 3);
    endtask

    task automatic test_short_line();
        apply_reset();
        add_frame(FRAME_H, 1);
        run_frames("short_line", 3);
    endtask

    task automatic test_sof_mid_frame();
        apply_reset();
        add_frame(1, -1);
        add_loose_beats(2);                             // Second line left unfinished
        add_frame(FRAME_H, -1);
        run_frames("sof_mid_frame", 3);
    endtask

    task automatic test_pre_sof_beats();
        apply_reset();
        add_loose_beats(3);
        add_frame(FRAME_H, -1);
        run_frames("pre_sof_beats", 3);
    endtask

    task automatic test_slow_ack();
        apply_reset();
        add_frame(FRAME_H, -1);
        add_frame(FRAME_H, -1);
        add_frame(FRAME_H, -1);
        run_frames("slow_ack", 100);
    endtask

    initial begin
        mon_axi4s         = 1'b0;
        rst               = 1'b1;
        frame_size.width  = X_BITS'(FRAME_W);
        frame_size.height = Y_BITS'(FRAME_H);
        pix_req           = 1'b0;
        pix_beat          = '0;
        rep_ack           = 1'b0;
        lfsr              = 16'd8;
        test_clean_frame();
        test_short_line();
        test_sof_mid_frame();
        test_pre_sof_beats();
        test_slow_ack();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* video_mon_properties.sv */
// Handshake checks for the pixel and report links of video_mon_top.
// Sampled on the rising clock edge; all but the reset check are off during reset.
module video_mon_properties import video_mon_pkg::*; (
    input logic          mon_axi4s,
    input logic          rst,
    input logic          pix_req,
    input logic          pix_ack,
    input logic          rep_req,
    input logic          rep_ack,
    input frame_report_t rep
);
    timeunit 1ns;
    timeprecision 1ps;

    ack_needs_req: assert property (@(posedge mon_axi4s) disable iff (rst)
        $rose(pix_ack) |-> $past(pix_req))                 // Only a request is answered
        else $error("pix_ack rose without pix_req");

    req_held: assert property (@(posedge mon_axi4s) disable iff (rst)
        rep_req && !rep_ack |=> rep_req)
        else $error("rep_req fell before rep_ack");

    rep_stable: assert property (@(posedge mon_axi4s) disable iff (rst)
        rep_req && $past(rep_req) |-> $stable(rep))        // Payload frozen during the request
        else $error("rep changed while rep_req was high");

    reset_idle: assert property (@(posedge mon_axi4s)
        $fell(rst) |-> !pix_ack && !rep_req)
        else $error("Links not idle after reset");

endmodule

bind video_mon_top video_mon_properties u_props (
    .mon_axi4s (mon_axi4s),
    .rst       (rst),
    .pix_req   (pix_req),
    .pix_ack   (pix_ack),
    .rep_req   (rep_req),
    .rep_ack   (rep_ack),
    .rep       (rep)
);

/* video_mon_top.sv */
// Video stream monitor: pixel link in, one frame report out per finished frame.
// Minimum latency from pix_ack of a completing beat to rep_req is 2 cycles.
// A slow rep_ack back-pressures the pixel link; held requests just wait.
module video_mon_top import video_mon_pkg::*; (
    input  logic              mon_axi4s,
    input  logic              rst,

    input  frame_size_t       frame_size,

    input  logic              pix_req,
    input  pixel_beat_t       pix_beat,
    output logic              pix_ack,

    output logic              rep_req,
    output frame_report_t     rep,
    input  logic              rep_ack,

    output logic [F_BITS-1:0] frame_num
);

    logic          beat_valid;
    logic          beat_ready;
    pixel_beat_t   beat;
    logic          rep_valid;
    logic          rep_ready;
    frame_report_t report;

    pixel_rx u_pixel_rx (
        .mon_axi4s  (mon_axi4s),
        .rst        (rst),
        .pix_req    (pix_req),
        .pix_beat   (pix_beat),
        .pix_ack    (pix_ack),
        .beat_ready (beat_ready),
        .beat_valid (beat_valid),
        .beat       (beat)
    );

    frame_monitor u_frame_monitor (
        .mon_axi4s  (mon_axi4s),
        .rst        (rst),
        .frame_size (frame_size),
        .beat_valid (beat_valid),
        .beat       (beat),
        .beat_ready (beat_ready),
        .rep_ready  (rep_ready),
        .rep_valid  (rep_valid),
        .report     (report)
    );

    report_tx u_report_tx (
        .mon_axi4s  (mon_axi4s),
        .rst        (rst),
        .rep_valid  (rep_valid),
        .report     (report),
        .rep_ready  (rep_ready),
        .rep_req    (rep_req),
        .rep        (rep),
        .rep_ack    (rep_ack),
        .frame_num  (frame_num)
    );

endmodule

/* report_tx.sv */
// Sending end of the four-phase report link.
// rep stays stable for the whole time rep_req is high.
// A new report is taken only after rep_ack has gone low again.
// frame_num counts acknowledged reports and wraps at 2**F_BITS.
module report_tx import video_mon_pkg::*; (
    input  logic              mon_axi4s,
    input  logic              rst,

    input  logic              rep_valid,
    input  frame_report_t     report,
    output logic              rep_ready,

    output logic              rep_req,
    output frame_report_t     rep,
    input  logic              rep_ack,

    output logic [F_BITS-1:0] frame_num
);

    typedef enum logic [1:0] {
        tx_idle,      // Free to take a report
        tx_req,       // Request raised, waiting for rep_ack
        tx_ack_low    // Request dropped, waiting for rep_ack to fall
    } tx_state_t;

    tx_state_t state;

    assign rep_ready = (state == tx_idle);

    always_ff @(posedge mon_axi4s) begin
        if (rst) begin
            state     <= tx_idle;
            rep_req   <= 1'b0;
            frame_num <= '0;
        end else begin
            case (state)
                tx_idle: begin
                    if (rep_valid) begin
                        rep_req <= 1'b1;            // Report handed over on this edge
                        state   <= tx_req;
                    end
                end
                tx_req: begin
                    if (rep_ack) begin
                        rep_req   <= 1'b0;
                        frame_num <= frame_num + 1'b1;
                        state     <= tx_ack_low;
                    end
                end
                default: begin
                    if (!rep_ack) begin
                        state <= tx_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge mon_axi4s) begin
        if (rep_valid && rep_ready) begin
            rep <= report;
        end
    end

endmodule

/* frame_monitor.sv */
// Watches the beat stream frame by frame and builds one report per finished frame.
// Beats before the first start-of-frame are dropped. A frame ends when its eol count
// reaches the height, or early when a new start-of-frame arrives (size_ok is then 0).
// Geometry is sampled from frame_size on every beat, so hold it steady during a frame.
module frame_monitor import video_mon_pkg::*; (
    input  logic          mon_axi4s,
    input  logic          rst,

    input  frame_size_t   frame_size,

    input  logic          beat_valid,
    input  pixel_beat_t   beat,
    output logic          beat_ready,

    input  logic          rep_ready,
    output logic          rep_valid,
    output frame_report_t report
);

    logic                     frame_open;
    logic [F_BITS-1:0]        frame_cnt;

    logic [X_BITS-1:0]        col_cnt;
    logic [Y_BITS-1:0]        line_cnt;
    logic [X_BITS+Y_BITS-1:0] pix_cnt;
    sums_t                    sum_acc;
    logic                     lines_ok;

    logic                     in_frame;
    logic                     close_by_sof;
    logic [X_BITS-1:0]        col_next;
    logic [Y_BITS-1:0]        line_next;
    logic [X_BITS+Y_BITS-1:0] pix_next;
    sums_t                    sum_next;
    logic                     ok_next;
    logic                     height_done;
    logic                     load;
    frame_report_t            rep_next;

    // Hold the pixel link off while a report waits for the sender
    assign beat_ready = !rep_valid;

    assign in_frame     = beat.sof || frame_open;  // This beat belongs to a frame
    assign close_by_sof = beat.sof && frame_open;  // It also cuts the old frame short

    // Counter values after this beat; a start-of-frame beat starts from zero
    always_comb begin
        col_next  = (beat.sof ? '0 : col_cnt) + 1'b1;
        line_next = (beat.sof ? '0 : line_cnt) + Y_BITS'(beat.eol);
        pix_next  = (beat.sof ? '0 : pix_cnt) + 1'b1;
        for (int i = 0; i < COMPONENTS; i++) begin
            sum_next[i] = (beat.sof ? '0 : sum_acc[i]) + SUM_BITS'(beat.data[i]);
        end
        // Every line must hold exactly width pixels
        ok_next     = (beat.sof || lines_ok) && !(beat.eol && col_next != frame_size.width);
        height_done = beat.eol && line_next == frame_size.height;
    end

    // Pick the report, if any, that this beat finishes
    always_comb begin
        load                 = 1'b0;
        rep_next.frame_id    = frame_cnt;
        rep_next.pixel_count = pix_next;
        rep_next.line_count  = line_next;
        rep_next.sums        = sum_next;
        rep_next.size_ok     = ok_next;
        if (beat_valid && in_frame && height_done) begin
            load = 1'b1;                                  // Frame reached its height
        end else if (beat_valid && close_by_sof) begin
            load                 = 1'b1;                  // Old frame without this beat
            rep_next.pixel_count = pix_cnt;
            rep_next.line_count  = line_cnt;
            rep_next.sums        = sum_acc;
            rep_next.size_ok     = 1'b0;
        end
    end

    always_ff @(posedge mon_axi4s) begin
        if (rst) begin
            frame_open <= 1'b0;
            rep_valid  <= 1'b0;
            frame_cnt  <= '0;
        end else begin
            if (rep_valid && rep_ready) begin
                rep_valid <= 1'b0;                        // Sender has taken the report
            end
            if (load) begin
                rep_valid <= 1'b1;
                frame_cnt <= frame_cnt + 1'b1;
            end
            if (beat_valid && in_frame) begin
                frame_open <= !height_done;
            end
        end
    end

    // Running counts of the open frame
    always_ff @(posedge mon_axi4s) begin
        if (beat_valid && in_frame) begin
            col_cnt  <= beat.eol ? '0 : col_next;
            line_cnt <= line_next;
            pix_cnt  <= pix_next;
            sum_acc  <= sum_next;
            lines_ok <= ok_next;
        end
    end

    always_ff @(posedge mon_axi4s) begin
        if (load) begin
            report <= rep_next;
        end
    end

endmodule

/* pixel_rx.sv */
// Receiving end of the four-phase pixel link.
// Each request yields exactly one beat strobe, however long pix_req is held.
// A request is only taken while beat_ready is high; otherwise it simply waits.
module pixel_rx import video_mon_pkg::*; (
    input  logic        mon_axi4s,
    input  logic        rst,

    input  logic        pix_req,
    input  pixel_beat_t pix_beat,
    output logic        pix_ack,

    input  logic        beat_ready,
    output logic        beat_valid,
    output pixel_beat_t beat
);

    logic accept;

    // A fresh request is one seen while the previous acknowledge has been withdrawn
    assign accept = pix_req && !pix_ack && beat_ready;

    always_ff @(posedge mon_axi4s) begin
        if (rst) begin
            pix_ack    <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= accept;                  // Strobe lasts a single cycle
            if (accept) begin
                pix_ack <= 1'b1;                   // Acknowledge together with the strobe
            end else if (!pix_req) begin
                pix_ack <= 1'b0;                   // Source has let go, close the cycle
            end
        end
    end

    // Payload is captured once per request and held for the monitor
    always_ff @(posedge mon_axi4s) begin
        if (accept) begin
            beat <= pix_beat;
        end
    end

endmodule

/* video_mon_pkg.sv */
// Shared sizes and payload types for the video stream monitor.
// Component 0 of a pixel always sits in the low bits; there is no endian option.
// Component sums wrap modulo 2**SUM_BITS, and the counters wrap at their widths.
package video_mon_pkg;

    localparam int COMPONENTS = 3;   // Colour components per pixel
    localparam int DATA_BITS  = 8;   // Bits per component
    localparam int X_BITS     = 12;  // Width of column and pixel-per-line counts
    localparam int Y_BITS     = 12;  // Width of line counts
    localparam int F_BITS     = 16;  // Width of the frame counter
    localparam int SUM_BITS   = 20;  // Width of each component sum

    // One pixel, component 0 in the low bits
    typedef logic [COMPONENTS-1:0][DATA_BITS-1:0] pixel_t;

    // Running or reported sum for every component
    typedef logic [COMPONENTS-1:0][SUM_BITS-1:0] sums_t;

    // One beat of the pixel link
    typedef struct packed {
        pixel_t data;
        logic   sof;   // Start of frame, first pixel of a frame
        logic   eol;   // Last pixel of a line
    } pixel_beat_t;

    // Expected frame geometry
    typedef struct packed {
        logic [X_BITS-1:0] width;
        logic [Y_BITS-1:0] height;
    } frame_size_t;

    // Summary of one finished frame
    typedef struct packed {
        logic [F_BITS-1:0]        frame_id;
        logic [X_BITS+Y_BITS-1:0] pixel_count;
        logic [Y_BITS-1:0]        line_count;
        sums_t                    sums;
        logic                     size_ok;
    } frame_report_t;

endpackage
